/* Bender.yml */
package:
  name: sifh

sources:
  - design/sifhPkg.sv
  - design/histRam.sv
  - design/histBuilder.sv
  - design/peakFinder.sv
  - design/sifhCtrl.sv
  - design/wbSlave.sv
  - design/sifhTop.sv
  - target: test
    files:
      - dv/sifhTb.sv

/* design/histBuilder.sv */
`timescale 1ns/100ps

module histBuilder import sifhPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    buildGo,
    input  logic    passSel,
    input  binIdxT  winLo,
    input  binIdxT  winHi,
    input  binIdxT  data,
    input  logic    dataValid,
    input  countT   ramRdData,
    output logic    wrEn,
    output ramAddrT rdAddr,
    output ramAddrT wrAddr,
    output countT   wrData,
    output logic    ramWrEn,
    output logic    buildDone
);

    logic [$clog2(eventsPerPass)-1:0] accCnt;
    logic       accept;
    logic       lastAcc;
    logic       inWin;
    logic [3:0] doneSh;   // delays the last accept until its write has settled

    logic    s1Valid;     // read issued, memory data arrives this cycle
    ramAddrT s1Addr;
    logic    s2Valid;     // write in flight
    ramAddrT s2Addr;
    countT   s2Data;
    logic    s3Valid;     // value written on the last edge
    ramAddrT s3Addr;
    countT   s3Data;
    countT   base;

    assign accept  = wrEn && dataValid;
    assign lastAcc = accept && (accCnt == ($bits(accCnt))'(eventsPerPass - 1));
    assign inWin   = !passSel || ((data >= winLo) && (data <= winHi)); // pass 1 counts all

    assign rdAddr  = {passSel, data};

    // newest in-flight value wins, the memory read misses both of them
    always_comb begin
        if (s2Valid && (s2Addr == s1Addr)) begin
            base = s2Data;
        end else if (s3Valid && (s3Addr == s1Addr)) begin
            base = s3Data;
        end else begin
            base = ramRdData;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wrEn    <= 1'b0;
            accCnt  <= '0;
            doneSh  <= '0;
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            if (buildGo) begin
                wrEn   <= 1'b1;
                accCnt <= '0;
            end else if (accept) begin
                accCnt <= accCnt + 1'b1;
                if (lastAcc) begin
                    wrEn <= 1'b0;                // pass is full
                end
            end
            doneSh  <= {doneSh[2:0], lastAcc};
            s1Valid <= accept && inWin;          // out-of-window events are dropped here
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr <= rdAddr;
        s2Addr <= s1Addr;
        s2Data <= base + 1'b1;
        s3Addr <= s2Addr;
        s3Data <= s2Data;
    end

    assign wrAddr    = s2Addr;
    assign wrData    = s2Data;
    assign ramWrEn   = s2Valid;
    assign buildDone = doneSh[3];

endmodule

/* design/histRam.sv */
`timescale 1ns/100ps

module histRam import sifhPkg::*; (
    input  logic    clk,
    input  logic    wrEn,
    input  ramAddrT wrAddr,
    input  ramAddrT rdAddr,
    input  countT   wrData,
    output countT   rdData
);

    countT mem [ramDepth];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

/* design/peakFinder.sv */
`timescale 1ns/100ps

module peakFinder import sifhPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    peakGo,
    input  logic    passSel,
    input  countT   ramRdData,
    output ramAddrT scanAddr,
    output binIdxT  peakBin,
    output countT   peakCount,
    output logic    peakDone
);

    logic   scanning;
    binIdxT rdIdx;      // bin being read
    logic   cmpValid;   // memory data of cmpIdx is on ramRdData
    binIdxT cmpIdx;

    assign scanAddr = {passSel, rdIdx};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            scanning  <= 1'b0;
            rdIdx     <= '0;
            cmpValid  <= 1'b0;
            cmpIdx    <= '0;
            peakBin   <= '0;
            peakCount <= '0;
            peakDone  <= 1'b0;
        end else begin
            cmpValid <= scanning;
            cmpIdx   <= rdIdx;
            peakDone <= cmpValid && (cmpIdx == binIdxT'(binNum - 1));
            if (peakGo) begin
                scanning  <= 1'b1;
                rdIdx     <= '0;
                peakBin   <= '0;
                peakCount <= '0;
            end else if (scanning) begin
                rdIdx <= rdIdx + 1'b1;
                if (rdIdx == binIdxT'(binNum - 1)) begin
                    scanning <= 1'b0;
                end
            end
            // strictly greater so a tie keeps the lower bin
            if (cmpValid && (ramRdData > peakCount)) begin
                peakBin   <= cmpIdx;
                peakCount <= ramRdData;
            end
        end
    end

endmodule

/* design/sifhCtrl.sv */
`timescale 1ns/100ps

module sifhCtrl import sifhPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    start,
    input  logic    buildDone,
    input  logic    peakDone,
    input  binIdxT  peakBin,
    input  countT   peakCount,
    input  ramAddrT bldRdAddr,
    input  ramAddrT bldWrAddr,
    input  countT   bldWrData,
    input  logic    bldWrEn,
    input  ramAddrT scanAddr,
    input  ramAddrT wbRdAddr,
    output logic    buildGo,
    output logic    passSel,
    output binIdxT  winLo,
    output binIdxT  winHi,
    output logic    peakGo,
    output logic    busy,
    output logic    done,
    output binIdxT  peak1,
    output binIdxT  peak2,
    output countT   peak2Count,
    output ramAddrT ramWrAddr,
    output ramAddrT ramRdAddr,
    output countT   ramWrData,
    output logic    ramWrEn
);

    // the result ports shadow the state names, so those states are package-qualified
    ctrlStateT state;
    ramAddrT   clrAddr;

    assign busy    = (state != idle);
    assign passSel = (state == build2) || (state == sifhPkg::peak2);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= idle;
            clrAddr    <= '0;
            buildGo    <= 1'b0;
            peakGo     <= 1'b0;
            done       <= 1'b0;
            winLo      <= '0;
            winHi      <= '0;
            peak1      <= '0;
            peak2      <= '0;
            peak2Count <= '0;
        end else begin
            buildGo <= 1'b0;
            peakGo  <= 1'b0;
            case (state)
                idle: if (start) begin
                    state   <= clear;
                    clrAddr <= '0;
                    done    <= 1'b0;
                end
                clear: begin
                    clrAddr <= clrAddr + 1'b1;           // one word per cycle
                    if (clrAddr == ramAddrT'(ramDepth - 1)) begin
                        state   <= build1;
                        buildGo <= 1'b1;
                    end
                end
                build1: if (buildDone) begin
                    state  <= sifhPkg::peak1;
                    peakGo <= 1'b1;
                end
                sifhPkg::peak1: if (peakDone) begin
                    peak1 <= peakBin;
                    state <= window;
                end
                window: begin
                    winLo   <= (peak1 < binIdxT'(thMinus)) ? '0 : peak1 - binIdxT'(thMinus);
                    winHi   <= (peak1 > binIdxT'(binNum - 1 - thPlus)) ?
                               binIdxT'(binNum - 1) : peak1 + binIdxT'(thPlus);
                    state   <= build2;
                    buildGo <= 1'b1;
                end
                build2: if (buildDone) begin
                    state  <= sifhPkg::peak2;
                    peakGo <= 1'b1;
                end
                sifhPkg::peak2: if (peakDone) begin
                    peak2      <= peakBin;
                    peak2Count <= peakCount;
                    done       <= 1'b1;
                    state      <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // memory port ownership
    always_comb begin
        ramRdAddr = wbRdAddr;               // host readout when nothing else reads
        ramWrAddr = bldWrAddr;
        ramWrData = bldWrData;
        ramWrEn   = 1'b0;
        case (state)
            clear: begin
                ramWrAddr = clrAddr;
                ramWrData = '0;
                ramWrEn   = 1'b1;
            end
            build1, build2: begin
                ramRdAddr = bldRdAddr;
                ramWrEn   = bldWrEn;
            end
            sifhPkg::peak1, sifhPkg::peak2: ramRdAddr = scanAddr;
            default: ;
        endcase
    end

endmodule

/* design/sifhPkg.sv */
package sifhPkg;

    localparam int binNum        = 64;
    localparam int ramDepth      = 2 * binNum;     // two histograms back to back
    localparam int eventsPerPass = 200;
    localparam int thMinus       = 4;              // window depth below the peak
    localparam int thPlus        = 5;              // window height above the peak

    typedef logic [$clog2(binNum)-1:0]   binIdxT;  // timestamp == bin index
    typedef logic [11:0]                 countT;
    typedef logic [$clog2(ramDepth)-1:0] ramAddrT; // msb selects histogram 2
    typedef logic [7:0]                  wbAdrT;
    typedef logic [15:0]                 wbDataT;

    typedef enum logic [2:0] {
        idle,
        clear,
        build1,
        peak1,
        window,
        build2,
        peak2
    } ctrlStateT;

    // bit 7 of the address selects the histogram memory instead of these registers
    localparam wbAdrT regCtrl       = 8'd0;
    localparam wbAdrT regStatus     = 8'd1;
    localparam wbAdrT regPeak1      = 8'd2;
    localparam wbAdrT regPeak2      = 8'd3;
    localparam wbAdrT regPeak2Count = 8'd4;

endpackage

/* design/sifhTop.sv */
`timescale 1ns/100ps

module sifhTop import sifhPkg::*; (
    input  logic   clk,
    input  logic   res,
    input  binIdxT data,
    input  logic   dataValid,
    input  logic   wbCyc,
    input  logic   wbStb,
    input  logic   wbWe,
    input  wbAdrT  wbAdr,
    input  wbDataT wbDatIn,
    output logic   wrEn,
    output wbDataT wbDatOut,
    output logic   wbAck
);

    logic    start;
    logic    busy;
    logic    done;
    logic    buildGo;
    logic    buildDone;
    logic    peakGo;
    logic    peakDone;
    logic    passSel;
    binIdxT  winLo;
    binIdxT  winHi;
    binIdxT  peakBin;
    countT   peakCount;
    binIdxT  peak1Res;
    binIdxT  peak2Res;
    countT   peak2CountRes;
    ramAddrT bldRdAddr;
    ramAddrT bldWrAddr;
    countT   bldWrData;
    logic    bldWrEn;
    ramAddrT scanAddr;
    ramAddrT wbRdAddr;
    ramAddrT ramWrAddr;
    ramAddrT ramRdAddr;
    countT   ramWrData;
    logic    ramWrEn;
    countT   ramRdData;

    sifhCtrl sifhCtrl_inst (
        .clk(clk), .res(res), .start(start), .buildDone(buildDone),
        .peakDone(peakDone), .peakBin(peakBin), .peakCount(peakCount),
        .bldRdAddr(bldRdAddr), .bldWrAddr(bldWrAddr), .bldWrData(bldWrData),
        .bldWrEn(bldWrEn), .scanAddr(scanAddr), .wbRdAddr(wbRdAddr),
        .buildGo(buildGo), .passSel(passSel), .winLo(winLo), .winHi(winHi),
        .peakGo(peakGo), .busy(busy), .done(done), .peak1(peak1Res),
        .peak2(peak2Res), .peak2Count(peak2CountRes), .ramWrAddr(ramWrAddr),
        .ramRdAddr(ramRdAddr), .ramWrData(ramWrData), .ramWrEn(ramWrEn)
    );

    histBuilder histBuilder_inst (
        .clk(clk), .res(res), .buildGo(buildGo), .passSel(passSel),
        .winLo(winLo), .winHi(winHi), .data(data), .dataValid(dataValid),
        .ramRdData(ramRdData), .wrEn(wrEn), .rdAddr(bldRdAddr),
        .wrAddr(bldWrAddr), .wrData(bldWrData), .ramWrEn(bldWrEn),
        .buildDone(buildDone)
    );

    peakFinder peakFinder_inst (
        .clk(clk), .res(res), .peakGo(peakGo), .passSel(passSel),
        .ramRdData(ramRdData), .scanAddr(scanAddr), .peakBin(peakBin),
        .peakCount(peakCount), .peakDone(peakDone)
    );

    histRam histRam_inst (
        .clk(clk), .wrEn(ramWrEn), .wrAddr(ramWrAddr), .rdAddr(ramRdAddr),
        .wrData(ramWrData), .rdData(ramRdData)
    );

    wbSlave wbSlave_inst (
        .clk(clk), .res(res), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
        .wbAdr(wbAdr), .wbDatIn(wbDatIn), .busy(busy), .done(done),
        .peak1(peak1Res), .peak2(peak2Res), .peak2Count(peak2CountRes),
        .ramRdData(ramRdData), .wbDatOut(wbDatOut), .wbAck(wbAck),
        .start(start), .wbRdAddr(wbRdAddr)
    );

endmodule

/* design/wbSlave.sv */
`timescale 1ns/100ps

module wbSlave import sifhPkg::*; (
    input  logic    clk,
    input  logic    res,
    input  logic    wbCyc,
    input  logic    wbStb,
    input  logic    wbWe,
    input  wbAdrT   wbAdr,
    input  wbDataT  wbDatIn,
    input  logic    busy,
    input  logic    done,
    input  binIdxT  peak1,
    input  binIdxT  peak2,
    input  countT   peak2Count,
    input  countT   ramRdData,
    output wbDataT  wbDatOut,
    output logic    wbAck,
    output logic    start,
    output ramAddrT wbRdAddr
);

    logic req;

    assign req      = wbCyc && wbStb && !wbAck;   // new strobe, not yet acked
    assign wbRdAddr = wbAdr[$bits(ramAddrT)-1:0]; // memory samples it on the ack edge

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wbAck <= 1'b0;
            start <= 1'b0;
        end else begin
            wbAck <= req;
            start <= req && wbWe && (wbAdr == regCtrl) && wbDatIn[0] && !busy;
        end
    end

    // address is held until the ack, memory data lands in the ack cycle
    always_comb begin
        wbDatOut = '0;
        if (wbAdr[7]) begin
            if (!busy) begin
                wbDatOut = wbDataT'(ramRdData);
            end
        end else begin
            case (wbAdr)
                regStatus:     wbDatOut = wbDataT'({done, busy});
                regPeak1:      wbDatOut = wbDataT'(peak1);
                regPeak2:      wbDatOut = wbDataT'(peak2);
                regPeak2Count: wbDatOut = wbDataT'(peak2Count);
                default:       wbDatOut = '0;
            endcase
        end
    end

endmodule

/* dv/sifhTb.sv */
`timescale 1ns/100ps

module sifhTb import sifhPkg::*; ();

    localparam int runCycles = 2 * eventsPerPass * 4 + 2 * (binNum + 2) + 128 + 200;

    logic   clk = 1'b0;
    logic   res;
    binIdxT data;
    logic   dataValid;
    logic   wbCyc;
    logic   wbStb;
    logic   wbWe;
    wbAdrT  wbAdr;
    wbDataT wbDatIn;
    logic   wrEn;
    wbDataT wbDatOut;
    logic   wbAck;

    logic [31:0] lcgState = 32'd13857;
    int     center;               // cluster of the current run
    int     prevTs;
    int     runAccepted;          // events taken in this run, both passes
    logic   runActive;
    logic   pass1Full;
    binIdxT batch1 [eventsPerPass];
    binIdxT batch2 [eventsPerPass];

    sifhTop sifhTop_inst (
        .clk(clk), .res(res), .data(data), .dataValid(dataValid),
        .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
        .wbDatIn(wbDatIn), .wrEn(wrEn), .wbDatOut(wbDatOut), .wbAck(wbAck)
    );

    always #5 clk = ~clk;

    task automatic stopWithError(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input int got, input int exp);
        assert (got == exp) else
            stopWithError($sformatf("mismatch at %0t ns: %s is %0d, expected %0d",
                                    $time, what, got, exp));
    endtask

    function automatic int nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return int'(lcgState[30:16]);
    endfunction

    // a quarter repeats, a quarter uniform, the rest clustered around center
    function automatic binIdxT newTimestamp();
        int r;
        int ts;
        r = nextRand();
        if (r % 4 == 0) begin
            ts = prevTs;
        end else if (r % 4 == 1) begin
            ts = nextRand() % binNum;
        end else begin
            ts = center + nextRand() % 7 - 3;
            ts = (ts < 0) ? 0 : ((ts > binNum - 1) ? binNum - 1 : ts);
        end
        prevTs = ts;
        return binIdxT'(ts);
    endfunction

    // strictly greater wins, so ties keep the lowest bin
    function automatic int peakOf(input int counts[binNum]);
        int best;
        best = 0;
        for (int b = 1; b < binNum; b++) begin
            if (counts[b] > counts[best]) best = b;
        end
        return best;
    endfunction

    task automatic wbAccess(input logic we, input wbAdrT adr, input wbDataT wdat,
                            output wbDataT rdat);
        int waitCnt;
        @(posedge clk);
        #1;
        wbCyc   = 1'b1;
        wbStb   = 1'b1;
        wbWe    = we;
        wbAdr   = adr;
        wbDatIn = wdat;
        waitCnt = 0;
        do begin
            @(negedge clk);
            waitCnt++;
        end while (!wbAck && waitCnt < 8);
        assert (wbAck) else stopWithError("the slave gave no Wishbone acknowledge in 8 cycles");
        rdat = wbDatOut;
        @(posedge clk);
        #1;
        wbCyc = 1'b0;
        wbStb = 1'b0;
        wbWe  = 1'b0;
    endtask

    task automatic wbRead(input wbAdrT adr, output wbDataT rdat);
        wbAccess(1'b0, adr, '0, rdat);
    endtask

    task automatic wbWrite(input wbAdrT adr, input wbDataT wdat);
        wbDataT dummy;
        wbAccess(1'b1, adr, wdat, dummy);
    endtask

    task automatic checkRun();
        int     cnt1 [binNum];
        int     cnt2 [binNum];
        int     h1 [binNum];
        int     p1;
        int     p2;
        int     lo;
        int     hi;
        int     sum;
        wbDataT rd;
        foreach (cnt1[b]) begin
            cnt1[b] = 0;
            cnt2[b] = 0;
        end
        foreach (batch1[i]) cnt1[batch1[i]]++;
        p1 = peakOf(cnt1);
        lo = (p1 - thMinus < 0) ? 0 : p1 - thMinus;
        hi = (p1 + thPlus > binNum - 1) ? binNum - 1 : p1 + thPlus;
        foreach (batch2[i]) begin
            if (batch2[i] >= lo && batch2[i] <= hi) cnt2[batch2[i]]++;
        end
        p2  = peakOf(cnt2);
        sum = 0;
        for (int b = 0; b < binNum; b++) begin
            wbRead(wbAdrT'(8'h80 + b), rd);
            h1[b] = rd;
            sum  += rd;
        end
        checkValue("histogram 1 sum", sum, eventsPerPass);
        for (int b = 0; b < binNum; b++) begin
            checkValue($sformatf("histogram 1 bin %0d", b), h1[b], cnt1[b]);
        end
        wbRead(regPeak1, rd);
        checkValue("peak1", rd, p1);
        for (int b = 0; b < binNum; b++) begin
            wbRead(wbAdrT'(8'hC0 + b), rd);   // zero outside the window in the model
            checkValue($sformatf("histogram 2 bin %0d", b), rd, cnt2[b]);
        end
        wbRead(regPeak2, rd);
        checkValue("peak2", rd, p2);
        wbRead(regPeak2Count, rd);
        checkValue("peak2 count", rd, cnt2[p2]);
    endtask

    task automatic doRun();
        wbDataT rd;
        @(negedge clk);
        #2;
        center      = 3 + nextRand() % (binNum - 6);
        prevTs      = center;
        runAccepted = 0;
        runActive   = 1'b1;
        wbWrite(regCtrl, 16'h0001);
        wbRead(regStatus, rd);
        checkValue("status while running", rd, 1);
        wait (runAccepted >= 50);
        wbWrite(regCtrl, 16'h0001);          // must be ignored
        wbRead(8'h80, rd);
        checkValue("memory read while busy", rd, 0);
        do begin
            wbRead(regStatus, rd);
        end while (rd[1] == 1'b0);
        checkValue("status at end of run", rd, 2);
        @(negedge clk);
        #2;
        runActive = 1'b0;
        checkRun();
    endtask

    // quiet outputs in reset
    always @(negedge clk) begin
        if (!res) begin
            assert (!wrEn && !wbAck) else
                stopWithError($sformatf("mismatch at %0t ns: wrEn or wbAck is high in reset",
                                        $time));
        end
    end

    assert property (@(posedge clk) disable iff (!res) $rose(wbCyc && wbStb) |=> wbAck)
        else stopWithError($sformatf("mismatch at %0t ns: wbAck missing after strobe", $time));
    assert property (@(posedge clk) disable iff (!res)
                     wbAck |-> $past(wbCyc && wbStb) && !$past(wbCyc && wbStb, 2))
        else stopWithError($sformatf("mismatch at %0t ns: wbAck without new strobe", $time));

    // timestamp source that holds its data until it is taken
    initial begin
        logic taken;
        data      = '0;
        dataValid = 1'b0;
        pass1Full = 1'b0;
        @(posedge res);
        forever begin
            @(negedge clk);
            if (!runActive || pass1Full || runAccepted == 2 * eventsPerPass) begin
                assert (!wrEn) else
                    stopWithError($sformatf("mismatch at %0t ns: wrEn high with no pass open",
                                            $time));
            end
            pass1Full = 1'b0;
            taken     = dataValid && wrEn;
            if (taken) begin
                if (runAccepted < eventsPerPass) begin
                    batch1[runAccepted] = data;
                end else begin
                    batch2[runAccepted - eventsPerPass] = data;
                end
                runAccepted++;
                pass1Full = (runAccepted == eventsPerPass);
            end
            @(posedge clk);
            #1;
            if (taken || !dataValid) begin
                if (nextRand() % 4 == 0) begin
                    dataValid = 1'b0;                 // random gap
                end else begin
                    dataValid = 1'b1;
                    data      = newTimestamp();
                end
            end
        end
    end

    initial begin
        #(2 * runCycles * 10 * 2);
        $display("timeout: the runs did not finish in the expected time");
        $display("ERRORS FOUND");
        $fatal(1);
    end

    initial begin
        wbDataT rd;
        res         = 1'b0;
        wbCyc       = 1'b0;
        wbStb       = 1'b0;
        wbWe        = 1'b0;
        wbAdr       = '0;
        wbDatIn     = '0;
        runActive   = 1'b0;
        runAccepted = 0;
        repeat (8) @(posedge clk);
        #1;
        res = 1'b1;
        wbRead(regStatus, rd);
        checkValue("status after reset", rd, 0);
        repeat (2) doRun();                 // second run proves the clear
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* filelist.f */
design/sifhPkg.sv
design/histRam.sv
design/histBuilder.sv
design/peakFinder.sv
design/sifhCtrl.sv
design/wbSlave.sv
design/sifhTop.sv
dv/sifhTb.sv
